// File: design/t08_params.svh
`ifndef T08_PARAMS_SVH
`define T08_PARAMS_SVH

// Data path width of the RV32I slice
`define T08_XLEN 32

// Architectural registers, x0 included
`define T08_NUM_REGS 32

// Program counter value after reset
`define T08_RESET_PC 32'h0000_0000

`endif

// File: design/t08_pkg.sv
`include "t08_params.svh"

package t08_pkg;

    typedef logic [`T08_XLEN-1:0] word_t;                   // Data, address and PC
    typedef logic [$clog2(`T08_NUM_REGS)-1:0] reg_idx_t;     // Register index

    typedef enum logic [5:0] {
        ADD   = 6'd1,  SUB   = 6'd2,  SLL   = 6'd3,  SLT   = 6'd4,   // R type
        SLTU  = 6'd5,  XOR   = 6'd6,  SRL   = 6'd7,  SRA   = 6'd8,
        OR    = 6'd9,  AND   = 6'd10,
        ADDI  = 6'd11, SLTI  = 6'd12, SLTIU = 6'd13, XORI  = 6'd14,  // I type
        ORI   = 6'd15, ANDI  = 6'd16, SLLI  = 6'd17, SRLI  = 6'd18,
        SRAI  = 6'd19,
        LB    = 6'd20, LH    = 6'd21, LW    = 6'd22, LBU   = 6'd23,  // Loads
        LHU   = 6'd24,
        SB    = 6'd25, SH    = 6'd26, SW    = 6'd27,                 // S type
        BEQ   = 6'd28, BNE   = 6'd29, BLT   = 6'd30, BGE   = 6'd31,  // B type
        BLTU  = 6'd32, BGEU  = 6'd33,
        AUIPC = 6'd35,                                               // U type
        JAL   = 6'd36,                                               // J type
        JALR  = 6'd37
    } alu_operations;

endpackage

// File: design/t08_decoder.sv
`timescale 1ns/1ps
`include "t08_params.svh"

module t08_decoder (
    input  t08_pkg::word_t         instr,
    output t08_pkg::alu_operations alu_control,
    output t08_pkg::word_t         immediate,
    output t08_pkg::reg_idx_t      rs1,
    output t08_pkg::reg_idx_t      rs2,
    output t08_pkg::reg_idx_t      rd,
    output logic                   reg_write,
    output logic                   is_load,
    output logic                   is_store,
    output logic                   is_jump,
    output logic                   illegal
);

    localparam logic [6:0] op_r_type = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_alt;                                  // Bit 30 picks SUB and SRA

    assign opcode     = instr[6:0];
    assign funct3     = instr[14:12];
    assign funct7_alt = instr[30];

    assign rd  = instr[11:7];
    assign rs2 = instr[24:20];
    assign rs1 = (opcode == op_lui) ? '0 : instr[19:15];     // LUI adds to x0

    always_comb begin : immediate_gen
        case (opcode)
            op_store:         immediate = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_branch:        immediate = {{19{instr[31]}}, instr[31], instr[7],
                                           instr[30:25], instr[11:8], 1'b0};
            op_lui, op_auipc: immediate = {instr[31:12], 12'b0};
            op_jal:           immediate = {{11{instr[31]}}, instr[31], instr[19:12],
                                           instr[20], instr[30:21], 1'b0};
            default:          immediate = {{20{instr[31]}}, instr[31:20]};  // I type
        endcase
    end

    always_comb begin : operation_decode
        alu_control = t08_pkg::ADD;
        reg_write   = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_jump     = 1'b0;
        illegal     = 1'b0;

        case (opcode)
            op_r_type: begin
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_control = funct7_alt ? t08_pkg::SUB : t08_pkg::ADD;
                    3'b001:  alu_control = t08_pkg::SLL;
                    3'b010:  alu_control = t08_pkg::SLT;
                    3'b011:  alu_control = t08_pkg::SLTU;
                    3'b100:  alu_control = t08_pkg::XOR;
                    3'b101:  alu_control = funct7_alt ? t08_pkg::SRA : t08_pkg::SRL;
                    3'b110:  alu_control = t08_pkg::OR;
                    default: alu_control = t08_pkg::AND;
                endcase
            end
            op_imm: begin
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_control = t08_pkg::ADDI;
                    3'b001:  alu_control = t08_pkg::SLLI;
                    3'b010:  alu_control = t08_pkg::SLTI;
                    3'b011:  alu_control = t08_pkg::SLTIU;
                    3'b100:  alu_control = t08_pkg::XORI;
                    3'b101:  alu_control = funct7_alt ? t08_pkg::SRAI : t08_pkg::SRLI;
                    3'b110:  alu_control = t08_pkg::ORI;
                    default: alu_control = t08_pkg::ANDI;
                endcase
            end
            op_load: begin
                reg_write = 1'b1;                            // Write-back drops it
                is_load   = 1'b1;
                case (funct3)
                    3'b000:  alu_control = t08_pkg::LB;
                    3'b001:  alu_control = t08_pkg::LH;
                    3'b010:  alu_control = t08_pkg::LW;
                    3'b100:  alu_control = t08_pkg::LBU;
                    3'b101:  alu_control = t08_pkg::LHU;
                    default: illegal     = 1'b1;
                endcase
            end
            op_store: begin
                is_store = 1'b1;
                case (funct3)
                    3'b000:  alu_control = t08_pkg::SB;
                    3'b001:  alu_control = t08_pkg::SH;
                    3'b010:  alu_control = t08_pkg::SW;
                    default: illegal     = 1'b1;
                endcase
            end
            op_branch: begin
                case (funct3)
                    3'b000:  alu_control = t08_pkg::BEQ;
                    3'b001:  alu_control = t08_pkg::BNE;
                    3'b100:  alu_control = t08_pkg::BLT;
                    3'b101:  alu_control = t08_pkg::BGE;
                    3'b110:  alu_control = t08_pkg::BLTU;
                    3'b111:  alu_control = t08_pkg::BGEU;
                    default: illegal     = 1'b1;
                endcase
            end
            op_lui: begin
                reg_write   = 1'b1;
                alu_control = t08_pkg::ADDI;                 // x0 plus U immediate
            end
            op_auipc: begin
                reg_write   = 1'b1;
                alu_control = t08_pkg::AUIPC;
            end
            op_jal: begin
                reg_write   = 1'b1;
                is_jump     = 1'b1;
                alu_control = t08_pkg::JAL;
            end
            op_jalr: begin
                reg_write   = 1'b1;
                is_jump     = 1'b1;
                alu_control = t08_pkg::JALR;
            end
            default: illegal = 1'b1;
        endcase

        // An illegal word must not touch any state
        if (illegal) begin
            alu_control = t08_pkg::ADD;
            reg_write   = 1'b0;
            is_load     = 1'b0;
            is_store    = 1'b0;
            is_jump     = 1'b0;
        end
    end

endmodule

// File: design/t08_register_file.sv
`timescale 1ns/1ps
`include "t08_params.svh"

module t08_register_file (
    input  logic              clk,
    input  logic              rst_n,
    input  t08_pkg::reg_idx_t rs1,
    input  t08_pkg::reg_idx_t rs2,
    output t08_pkg::word_t    rs1_data,
    output t08_pkg::word_t    rs2_data,
    input  logic              we,
    input  t08_pkg::reg_idx_t waddr,
    input  t08_pkg::word_t    wdata
);

    t08_pkg::word_t regs [1:`T08_NUM_REGS-1];                // No storage for x0

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `T08_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Reads see the old value during a same-cycle write
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: design/t08_alu.sv
`timescale 1ns/1ps

module t08_alu (
    input  t08_pkg::word_t         reg1,
    input  t08_pkg::word_t         reg2,
    input  t08_pkg::word_t         immediate,
    input  t08_pkg::word_t         program_counter,
    input  t08_pkg::alu_operations alu_control,
    output t08_pkg::word_t         data_out,
    output logic                   branch
);

    t08_pkg::word_t in1;                                     // Operands after selection
    t08_pkg::word_t in2;

    always_comb begin : input_multiplexer
        case (alu_control)
            t08_pkg::ADDI, t08_pkg::SLTI, t08_pkg::SLTIU, t08_pkg::XORI,
            t08_pkg::ORI, t08_pkg::ANDI, t08_pkg::SLLI, t08_pkg::SRLI,
            t08_pkg::SRAI, t08_pkg::LB, t08_pkg::LH, t08_pkg::LW,
            t08_pkg::LBU, t08_pkg::LHU, t08_pkg::SB, t08_pkg::SH,
            t08_pkg::SW, t08_pkg::JALR: begin
                in1 = reg1;
                in2 = immediate;
            end
            t08_pkg::AUIPC: begin
                in1 = program_counter;
                in2 = immediate;
            end
            default: begin                                   // R type and branches
                in1 = reg1;
                in2 = reg2;
            end
        endcase
    end

    always_comb begin : operation_select
        data_out = '0;
        branch   = 1'b0;

        case (alu_control)
            t08_pkg::ADD, t08_pkg::ADDI, t08_pkg::LB, t08_pkg::LH,
            t08_pkg::LW, t08_pkg::LBU, t08_pkg::LHU, t08_pkg::SB,
            t08_pkg::SH, t08_pkg::SW, t08_pkg::AUIPC,
            t08_pkg::JALR:                  data_out = in1 + in2;
            t08_pkg::SUB:                   data_out = in1 - in2;
            t08_pkg::SLL, t08_pkg::SLLI:    data_out = in1 << in2[4:0];
            t08_pkg::SLT, t08_pkg::SLTI:    data_out = {31'b0, $signed(in1) < $signed(in2)};
            t08_pkg::SLTU, t08_pkg::SLTIU:  data_out = {31'b0, in1 < in2};
            t08_pkg::XOR, t08_pkg::XORI:    data_out = in1 ^ in2;
            t08_pkg::SRL, t08_pkg::SRLI:    data_out = in1 >> in2[4:0];
            t08_pkg::SRA, t08_pkg::SRAI:    data_out = $signed(in1) >>> in2[4:0];
            t08_pkg::OR, t08_pkg::ORI:      data_out = in1 | in2;
            t08_pkg::AND, t08_pkg::ANDI:    data_out = in1 & in2;

            t08_pkg::BEQ:   branch = (in1 == in2);
            t08_pkg::BNE:   branch = (in1 != in2);
            t08_pkg::BLT:   branch = ($signed(in1) < $signed(in2));
            t08_pkg::BGE:   branch = ($signed(in1) >= $signed(in2));
            t08_pkg::BLTU:  branch = (in1 < in2);
            t08_pkg::BGEU:  branch = (in1 >= in2);

            default: begin                                   // JAL target is in the PC unit
                data_out = '0;
                branch   = 1'b0;
            end
        endcase
    end

endmodule

// File: design/t08_pc_unit.sv
`timescale 1ns/1ps
`include "t08_params.svh"

module t08_pc_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  t08_pkg::alu_operations alu_control,
    input  t08_pkg::word_t         immediate,
    input  t08_pkg::word_t         alu_result,
    input  logic                   branch,
    output t08_pkg::word_t         pc,
    output t08_pkg::word_t         link
);

    t08_pkg::word_t next_pc;

    assign link = pc + 32'd4;                                // Return address

    always_comb begin
        if (branch || (alu_control == t08_pkg::JAL)) begin
            next_pc = pc + immediate;                        // PC relative target
        end else if (alu_control == t08_pkg::JALR) begin
            next_pc = {alu_result[31:1], 1'b0};              // Bit 0 cleared
        end else begin
            next_pc = link;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `T08_RESET_PC;
        end else if (instr_valid) begin
            pc <= next_pc;
        end
    end

endmodule

// File: design/t08_writeback.sv
`timescale 1ns/1ps

module t08_writeback (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  t08_pkg::reg_idx_t rd,
    input  logic              reg_write,
    input  logic              is_load,
    input  logic              is_store,
    input  logic              is_jump,
    input  logic              illegal,
    input  logic              branch,
    input  t08_pkg::word_t    alu_result,
    input  t08_pkg::word_t    link,
    output logic              rf_we,
    output t08_pkg::reg_idx_t rf_waddr,
    output t08_pkg::word_t    rf_wdata,
    output logic              wb_valid,
    output logic              wb_we,
    output t08_pkg::reg_idx_t wb_rd,
    output t08_pkg::word_t    wb_data,
    output logic              branch_taken,
    output logic              mem_read,
    output logic              mem_write,
    output logic              illegal_out,
    output t08_pkg::word_t    mem_addr
);

    // Loads have no data to write and x0 stays zero
    assign rf_we    = instr_valid && reg_write && !is_load && (rd != '0);
    assign rf_waddr = rd;
    assign rf_wdata = is_jump ? link : alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid     <= 1'b0;
            wb_we        <= 1'b0;
            branch_taken <= 1'b0;
            mem_read     <= 1'b0;
            mem_write    <= 1'b0;
            illegal_out  <= 1'b0;
        end else begin
            wb_valid     <= instr_valid;                     // One cycle per instruction
            wb_we        <= rf_we;
            branch_taken <= instr_valid && branch;
            mem_read     <= instr_valid && is_load;
            mem_write    <= instr_valid && is_store;
            illegal_out  <= instr_valid && illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin                               // Payload holds when idle
            wb_rd    <= rf_waddr;
            wb_data  <= rf_wdata;
            mem_addr <= alu_result;
        end
    end

endmodule

// File: design/t08_execute.sv
`timescale 1ns/1ps

module t08_execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  t08_pkg::word_t    instr,
    output t08_pkg::word_t    pc,
    output logic              wb_valid,
    output logic              wb_we,
    output t08_pkg::reg_idx_t wb_rd,
    output t08_pkg::word_t    wb_data,
    output logic              branch_taken,
    output logic              mem_read,
    output logic              mem_write,
    output logic              illegal,
    output t08_pkg::word_t    mem_addr
);

    t08_pkg::alu_operations alu_control;
    t08_pkg::word_t         immediate;
    t08_pkg::reg_idx_t      rs1;
    t08_pkg::reg_idx_t      rs2;
    t08_pkg::reg_idx_t      rd;
    logic                   reg_write;
    logic                   is_load;
    logic                   is_store;
    logic                   is_jump;
    logic                   dec_illegal;                     // Unregistered decode flag

    t08_pkg::word_t         rs1_data;
    t08_pkg::word_t         rs2_data;
    t08_pkg::word_t         alu_result;
    logic                   branch;
    t08_pkg::word_t         link;

    logic                   rf_we;
    t08_pkg::reg_idx_t      rf_waddr;
    t08_pkg::word_t         rf_wdata;

    t08_decoder decoder_i (
        .instr       (instr),
        .alu_control (alu_control),
        .immediate   (immediate),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .reg_write   (reg_write),
        .is_load     (is_load),
        .is_store    (is_store),
        .is_jump     (is_jump),
        .illegal     (dec_illegal)
    );

    t08_register_file register_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata)
    );

    t08_alu alu_i (
        .reg1            (rs1_data),
        .reg2            (rs2_data),
        .immediate       (immediate),
        .program_counter (pc),
        .alu_control     (alu_control),
        .data_out        (alu_result),
        .branch          (branch)
    );

    t08_pc_unit pc_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .alu_control (alu_control),
        .immediate   (immediate),
        .alu_result  (alu_result),
        .branch      (branch),
        .pc          (pc),
        .link        (link)
    );

    t08_writeback writeback_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .rd           (rd),
        .reg_write    (reg_write),
        .is_load      (is_load),
        .is_store     (is_store),
        .is_jump      (is_jump),
        .illegal      (dec_illegal),
        .branch       (branch),
        .alu_result   (alu_result),
        .link         (link),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .wb_valid     (wb_valid),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .branch_taken (branch_taken),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .illegal_out  (illegal),
        .mem_addr     (mem_addr)
    );

endmodule

// File: sim/t08_execute_properties.sv
`timescale 1ns/1ps
`include "t08_params.svh"

module t08_execute_properties (
    input logic              clk,
    input logic              rst_n,
    input logic              instr_valid,
    input logic              wb_valid,
    input logic              wb_we,
    input t08_pkg::reg_idx_t wb_rd,
    input logic              mem_read,
    input logic              mem_write,
    input t08_pkg::word_t    pc
);

    int failures = 0;                                        // Failed assertions so far

    mem_strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write are high together");
            failures++;
        end

    // No result without an instruction in the cycle before
    wb_follows_instr: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> $past(instr_valid))
        else begin
            $error("wb_valid without instr_valid in the previous cycle");
            failures++;
        end

    no_write_to_x0: assert property (@(posedge clk) disable iff (!rst_n)
        wb_we |-> (wb_rd != '0))
        else begin
            $error("wb_we is high with wb_rd equal to x0");
            failures++;
        end

    reset_state: assert property (@(posedge clk)
        !rst_n |=> (pc == `T08_RESET_PC) && !wb_valid && !wb_we && !mem_read && !mem_write)
        else begin
            $error("outputs not in reset state after a reset cycle");
            failures++;
        end

endmodule

bind t08_execute t08_execute_properties properties_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .wb_valid    (wb_valid),
    .wb_we       (wb_we),
    .wb_rd       (wb_rd),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .pc          (pc)
);

// File: sim/t08_execute_tb.sv
`timescale 1ns/1ps
`include "t08_params.svh"

module t08_execute_tb;

    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;

    typedef struct {
        t08_pkg::word_t    instr;
        logic              we;
        t08_pkg::reg_idx_t rd;
        t08_pkg::word_t    data;
        logic              taken;
        logic              mem_rd;
        logic              mem_wr;
        t08_pkg::word_t    addr;
        logic              ill;
        t08_pkg::word_t    next_pc;
    } row_t;

    logic              clk;
    logic              rst_n;
    logic              instr_valid;
    t08_pkg::word_t    instr;
    t08_pkg::word_t    pc;
    logic              wb_valid;
    logic              wb_we;
    t08_pkg::reg_idx_t wb_rd;
    t08_pkg::word_t    wb_data;
    logic              branch_taken;
    logic              mem_read;
    logic              mem_write;
    logic              illegal;
    t08_pkg::word_t    mem_addr;

    row_t           rows[$];
    t08_pkg::word_t build_pc;                                // PC while the table is built
    int             cur_row;
    int             errors;
    int             timeouts;

    t08_execute t08_execute_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // RV32I instruction encoders with fields in assembly order
    function automatic t08_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
            input t08_pkg::reg_idx_t rd, input t08_pkg::reg_idx_t rs1, input t08_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic t08_pkg::word_t enc_i(input logic [6:0] op, input logic [2:0] f3,
            input t08_pkg::reg_idx_t rd, input t08_pkg::reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic t08_pkg::word_t enc_s(input logic [2:0] f3, input t08_pkg::reg_idx_t rs2,
            input t08_pkg::reg_idx_t rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic t08_pkg::word_t enc_b(input logic [2:0] f3, input t08_pkg::reg_idx_t rs1,
            input t08_pkg::reg_idx_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic t08_pkg::word_t enc_u(input logic [6:0] op, input t08_pkg::reg_idx_t rd,
            input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic t08_pkg::word_t enc_j(input t08_pkg::reg_idx_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic push_row(input t08_pkg::word_t instr_w, input logic we,
            input t08_pkg::reg_idx_t rd, input t08_pkg::word_t data, input logic taken,
            input logic mem_rd, input logic mem_wr, input t08_pkg::word_t addr,
            input logic ill, input t08_pkg::word_t next_pc);
        row_t r;
        r = '{instr_w, we, rd, data, taken, mem_rd, mem_wr, addr, ill, next_pc};
        rows.push_back(r);
        build_pc = next_pc;
    endtask

    task automatic put_write(input t08_pkg::word_t instr_w, input t08_pkg::reg_idx_t rd,
            input t08_pkg::word_t data);
        push_row(instr_w, 1'b1, rd, data, 1'b0, 1'b0, 1'b0, '0, 1'b0, build_pc + 32'd4);
    endtask

    task automatic put_branch(input t08_pkg::word_t instr_w, input logic taken,
            input t08_pkg::word_t offset);
        push_row(instr_w, 1'b0, '0, '0, taken, 1'b0, 1'b0, '0, 1'b0,
                 taken ? build_pc + offset : build_pc + 32'd4);
    endtask

    task automatic put_jump(input t08_pkg::word_t instr_w, input t08_pkg::reg_idx_t rd,
            input t08_pkg::word_t target);
        push_row(instr_w, 1'b1, rd, build_pc + 32'd4, 1'b0, 1'b0, 1'b0, '0, 1'b0, target);
    endtask

    task automatic put_mem(input t08_pkg::word_t instr_w, input logic store,
            input t08_pkg::word_t addr);
        push_row(instr_w, 1'b0, '0, '0, 1'b0, !store, store, addr, 1'b0, build_pc + 32'd4);
    endtask

    task automatic put_quiet(input t08_pkg::word_t instr_w, input logic ill);
        push_row(instr_w, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0, '0, ill, build_pc + 32'd4);
    endtask

    task automatic check_word(input string what, input t08_pkg::word_t got,
            input t08_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t row %0d %s: got %h, expected %h", $time, cur_row, what, got, exp);
        end
    endtask

    task automatic check_index(input string what, input t08_pkg::reg_idx_t got,
            input t08_pkg::reg_idx_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t row %0d %s: got x%0d, expected x%0d", $time, cur_row, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t row %0d %s: got %b, expected %b", $time, cur_row, what, got, exp);
        end
    endtask

    task automatic wait_wb(output bit ok);
        int cycles;
        cycles = 0;
        while (!wb_valid && cycles < 10) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = wb_valid;
    endtask

    initial begin : main
        integer         seed;
        logic [11:0]    imm_a;
        logic [11:0]    imm_b;
        t08_pkg::word_t rand_sum;
        bit             ok;
        int             assert_fails;
        seed        = 32'hdf12;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        errors      = 0;
        timeouts    = 0;
        cur_row     = 0;
        build_pc    = `T08_RESET_PC;
        imm_a       = $random(seed);
        imm_b       = $random(seed);
        rand_sum    = {{20{imm_a[11]}}, imm_a} + {{20{imm_b[11]}}, imm_b};   // Sign extended sum

        put_write(enc_u(op_lui, 1, 20'h12345), 1, 32'h1234_5000);
        put_write(enc_i(op_imm, 0, 1, 1, 12'h678), 1, 32'h1234_5678);
        put_write(enc_i(op_imm, 0, 2, 0, -8), 2, 32'hffff_fff8);
        put_write(enc_i(op_imm, 0, 3, 0, 3), 3, 32'd3);
        put_write(enc_r(7'h00, 0, 4, 1, 3), 4, 32'h1234_567b);          // add
        put_write(enc_r(7'h20, 0, 5, 3, 1), 5, 32'hedcb_a98b);          // sub
        put_write(enc_r(7'h00, 1, 6, 1, 3), 6, 32'h91a2_b3c0);          // sll
        put_write(enc_r(7'h00, 2, 7, 2, 3), 7, 32'd1);                  // -8 < 3 signed
        put_write(enc_r(7'h00, 3, 8, 2, 3), 8, 32'd0);                  // But not unsigned
        put_write(enc_r(7'h00, 4, 9, 1, 2), 9, 32'hedcb_a980);          // xor
        put_write(enc_r(7'h00, 5, 10, 2, 3), 10, 32'h1fff_ffff);        // srl
        put_write(enc_r(7'h20, 5, 11, 2, 3), 11, 32'hffff_ffff);        // sra keeps the sign
        put_write(enc_r(7'h00, 6, 12, 1, 3), 12, 32'h1234_567b);        // or
        put_write(enc_r(7'h00, 7, 13, 1, 5), 13, 32'h0000_0008);        // and
        put_write(enc_i(op_imm, 7, 14, 1, 12'h0f0), 14, 32'h0000_0070);
        put_write(enc_i(op_imm, 6, 15, 3, 12'h100), 15, 32'h0000_0103);
        put_write(enc_i(op_imm, 4, 16, 1, -1), 16, 32'hedcb_a987);
        put_write(enc_i(op_imm, 2, 17, 2, -7), 17, 32'd1);
        put_write(enc_i(op_imm, 3, 18, 2, -7), 18, 32'd1);
        put_write(enc_i(op_imm, 1, 19, 3, 4), 19, 32'h0000_0030);
        put_write(enc_i(op_imm, 5, 20, 2, 12'h401), 20, 32'hffff_fffc); // srai by 1
        put_write(enc_i(op_imm, 5, 21, 2, 28), 21, 32'h0000_000f);
        put_write(enc_i(op_imm, 0, 22, 0, imm_a), 22, {{20{imm_a[11]}}, imm_a});
        put_write(enc_i(op_imm, 0, 23, 22, imm_b), 23, rand_sum);
        put_write(enc_r(7'h00, 0, 24, 23, 3), 24, rand_sum + 32'd3);

        put_branch(enc_b(0, 3, 3, 12), 1'b1, 12);                       // beq
        put_branch(enc_b(0, 3, 2, 12), 1'b0, 12);
        put_branch(enc_b(1, 3, 2, 12), 1'b1, 12);                       // bne
        put_branch(enc_b(1, 3, 3, 12), 1'b0, 12);
        put_branch(enc_b(4, 2, 3, 12), 1'b1, 12);                       // blt
        put_branch(enc_b(4, 3, 2, 12), 1'b0, 12);
        put_branch(enc_b(5, 3, 2, 12), 1'b1, 12);                       // bge
        put_branch(enc_b(5, 2, 3, 12), 1'b0, 12);
        put_branch(enc_b(6, 3, 2, 12), 1'b1, 12);                       // bltu
        put_branch(enc_b(6, 2, 3, 12), 1'b0, 12);
        put_branch(enc_b(7, 2, 3, -16), 1'b1, -16);                     // bgeu backward
        put_branch(enc_b(7, 3, 2, -16), 1'b0, -16);

        put_jump(enc_j(25, 21'h40), 25, build_pc + 32'h40);
        put_jump(enc_i(op_jalr, 0, 26, 3, 12'h200), 26, 32'h0000_0202); // Bit 0 dropped
        put_write(enc_u(op_auipc, 27, 20'h1), 27, build_pc + 32'h1000);
        put_mem(enc_i(op_load, 2, 28, 1, 8), 1'b0, 32'h1234_5680);      // lw
        put_mem(enc_s(2, 3, 1, -4), 1'b1, 32'h1234_5674);               // sw
        put_quiet(enc_i(op_imm, 0, 0, 0, 5), 1'b0);                     // x0 write dropped
        put_write(enc_r(7'h00, 0, 29, 0, 3), 29, 32'd3);
        put_quiet(32'hffff_ffff, 1'b1);                                 // Unknown opcode

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_word("reset pc", pc, `T08_RESET_PC);
        check_flag("reset wb_valid", wb_valid, 1'b0);
        check_flag("reset wb_we", wb_we, 1'b0);
        check_flag("reset branch_taken", branch_taken, 1'b0);
        check_flag("reset mem_read", mem_read, 1'b0);
        check_flag("reset mem_write", mem_write, 1'b0);
        check_flag("reset illegal", illegal, 1'b0);

        foreach (rows[i]) begin
            cur_row     = i + 1;
            instr       = rows[i].instr;
            instr_valid = 1'b1;
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
            wait_wb(ok);
            if (!ok) begin
                timeouts++;
                $display("Timeout: wb_valid never rose for row %0d", cur_row);
                break;
            end
            check_flag("wb_we", wb_we, rows[i].we);
            if (rows[i].we) begin
                check_index("wb_rd", wb_rd, rows[i].rd);
                check_word("wb_data", wb_data, rows[i].data);
            end
            check_flag("branch_taken", branch_taken, rows[i].taken);
            check_flag("mem_read", mem_read, rows[i].mem_rd);
            check_flag("mem_write", mem_write, rows[i].mem_wr);
            check_flag("illegal", illegal, rows[i].ill);
            if (rows[i].mem_rd || rows[i].mem_wr)
                check_word("mem_addr", mem_addr, rows[i].addr);
            check_word("pc", pc, rows[i].next_pc);
        end

        assert_fails = t08_execute_i.properties_i.failures;
        $display("Rows: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
                 rows.size(), errors, timeouts, assert_fails);
        if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+design
design/t08_pkg.sv
design/t08_decoder.sv
design/t08_register_file.sv
design/t08_alu.sv
design/t08_pc_unit.sv
design/t08_writeback.sv
design/t08_execute.sv
sim/t08_execute_properties.sv
sim/t08_execute_tb.sv

// File: Bender.yml
package:
  name: t08_execute

sources:
  - include_dirs:
      - design
    files:
      - design/t08_pkg.sv
      - design/t08_decoder.sv
      - design/t08_register_file.sv
      - design/t08_alu.sv
      - design/t08_pc_unit.sv
      - design/t08_writeback.sv
      - design/t08_execute.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/t08_execute_properties.sv
      - sim/t08_execute_tb.sv
